// File: logic/regfile_pkg.sv
package regfile_pkg;

	// default register file shape
	localparam int default_data_width = 32; // bits per register
	localparam int default_addr_width = 5;  // 32 registers

	// write handshake controller
	// one pass through the three states per four-phase handshake
	typedef enum logic [1:0]
	{
		wr_idle   = 2'b00, // waiting for a request
		wr_commit = 2'b01, // write strobe to the bank is active
		wr_done   = 2'b10  // ack high until the request drops
	} wr_state_t;

endpackage

// File: logic/write_port.sv
module write_port
	import regfile_pkg::*;
#(
	parameter int data_width = default_data_width,
	parameter int addr_width = default_addr_width
)
(
	input logic e,
	input logic reset,

	// four-phase request side
	input logic wr_req,
	input logic [addr_width-1:0] wr_addr,
	input logic [data_width-1:0] wr_data,
	output logic wr_ack,

	// towards the register bank
	output logic we,
	output logic [addr_width-1:0] waddr,
	output logic [data_width-1:0] wdata
);

	wr_state_t state;
	wr_state_t state_next;

	logic accept;   // request taken on this edge
	logic ack_drop; // requester has let go of wr_req

	// a request is only looked at while idle
	// so the edge that drops wr_ack never accepts a new one
	assign accept = (state == wr_idle) && wr_req;
	assign ack_drop = (state == wr_done) && !wr_req;

	always_comb
	begin
		state_next = state;
		case (state)
			wr_idle:
			begin
				if (accept)
				begin
					state_next = wr_commit;
				end
			end
			wr_commit:
			begin
				state_next = wr_done; // strobe lasts one cycle
			end
			wr_done:
			begin
				if (ack_drop)
				begin
					state_next = wr_idle;
				end
			end
			default:
			begin
				state_next = wr_idle; // unused encoding
			end
		endcase
	end

	always_ff @(posedge e)
	begin
		if (reset)
		begin
			state <= wr_idle;
		end
		else
		begin
			state <= state_next;
		end
	end

	// we is high exactly while in wr_commit
	// the bank takes the data on the edge that leaves wr_commit
	always_ff @(posedge e)
	begin
		if (reset)
		begin
			we <= 1'b0;
		end
		else
		begin
			we <= accept;
		end
	end

	// ack rises on the same edge the bank is written
	// and stays up for as long as the requester holds wr_req
	always_ff @(posedge e)
	begin
		if (reset)
		begin
			wr_ack <= 1'b0;
		end
		else if (state == wr_commit)
		begin
			wr_ack <= 1'b1;
		end
		else if (ack_drop)
		begin
			wr_ack <= 1'b0;
		end
	end

	// address and data only need to be valid on the accepting edge
	always_ff @(posedge e)
	begin
		if (accept)
		begin
			waddr <= wr_addr;
			wdata <= wr_data;
		end
	end

endmodule

// File: logic/reg_bank.sv
module reg_bank
	import regfile_pkg::*;
#(
	parameter int data_width = default_data_width,
	parameter int addr_width = default_addr_width
)
(
	input logic e,
	input logic reset,

	// single write port, we is a one-cycle strobe
	input logic we,
	input logic [addr_width-1:0] waddr,
	input logic [data_width-1:0] wdata,

	// two independent read ports
	input logic [addr_width-1:0] rd_addr_a,
	input logic [addr_width-1:0] rd_addr_b,
	output logic [data_width-1:0] rd_data_a,
	output logic [data_width-1:0] rd_data_b
);

	localparam int depth = 1 << addr_width;

	logic [data_width-1:0] regs [depth];
	logic [depth-1:0] wsel; // one-hot write select

	// write address decoder
	// every entry from 0 to depth-1 gets its own select line
	for (genvar i = 0; i < depth; i++)
	begin : g_decode
		assign wsel[i] = we && (waddr == addr_width'(i));
	end

	always_ff @(posedge e)
	begin
		if (reset)
		begin
			for (int i = 0; i < depth; i++)
			begin
				regs[i] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < depth; i++)
			begin
				if (wsel[i])
				begin
					regs[i] <= wdata;
				end
			end
		end
	end

	// reads are combinational and see the written value
	// from the edge after the strobe
	always_comb
	begin
		rd_data_a = regs[rd_addr_a]; // port a
	end

	always_comb
	begin
		rd_data_b = regs[rd_addr_b]; // port b
	end

endmodule

// File: logic/register_file.sv
module register_file
	import regfile_pkg::*;
#(
	parameter int data_width = default_data_width,
	parameter int addr_width = default_addr_width
)
(
	input logic e,
	input logic reset,

	// write side with four-phase handshake
	input logic wr_req,
	input logic [addr_width-1:0] wr_addr,
	input logic [data_width-1:0] wr_data,
	output logic wr_ack,

	// read side without handshake
	input logic [addr_width-1:0] rd_addr_a,
	input logic [addr_width-1:0] rd_addr_b,
	output logic [data_width-1:0] rd_data_a,
	output logic [data_width-1:0] rd_data_b
);

	// write strobe with the captured address and data
	logic we;
	logic [addr_width-1:0] waddr;
	logic [data_width-1:0] wdata;

	// accept edge to ack edge is two cycles
	write_port #(
		.data_width(data_width),
		.addr_width(addr_width)
	) u_write_port (
		.e(e),
		.reset(reset),
		.wr_req(wr_req),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_ack(wr_ack),
		.we(we),
		.waddr(waddr),
		.wdata(wdata)
	);

	reg_bank #(
		.data_width(data_width),
		.addr_width(addr_width)
	) u_reg_bank (
		.e(e),
		.reset(reset),
		.we(we),
		.waddr(waddr),
		.wdata(wdata),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b)
	);

endmodule

// File: verif/write_port_chk.sv
module write_port_chk
	import regfile_pkg::*;
(
	input logic e,
	input logic reset,
	input logic wr_req,
	input logic wr_ack,
	input logic we,
	input wr_state_t state
);

	timeunit 1ns;
	timeprecision 1ps;

	logic accept; // controller takes the request on this edge

	assign accept = (state == wr_idle) && wr_req;

	ack_needs_req: assert property (@(posedge e) disable iff (reset) $rose(wr_ack) |-> wr_req)
		else $error("wr_ack rose while wr_req was low");

	ack_holds: assert property (@(posedge e) disable iff (reset) (wr_ack && wr_req) |=> wr_ack)
		else $error("wr_ack fell while wr_req was still high");

	// one strobe per accepted request, never two in a row
	strobe_before_ack: assert property (@(posedge e) disable iff (reset)
		$rose(wr_ack) |-> $past(we))
		else $error("wr_ack rose without a write strobe the cycle before");

	we_one_cycle: assert property (@(posedge e) disable iff (reset) we |=> !we)
		else $error("write strobe lasted more than one cycle");

	ack_two_cycles: assert property (@(posedge e) disable iff (reset) accept |-> ##2 wr_ack)
		else $error("wr_ack not high two cycles after acceptance");

endmodule

// File: verif/register_file_monitor.sv
module register_file_monitor
	import regfile_pkg::*;
#(
	parameter int data_width = default_data_width,
	parameter int addr_width = default_addr_width
)
(
	input logic e,
	input logic reset,
	input logic wr_req,
	input logic [addr_width-1:0] wr_addr,
	input logic [data_width-1:0] wr_data,
	input logic wr_ack,
	input logic [addr_width-1:0] rd_addr_a,
	input logic [addr_width-1:0] rd_addr_b,
	input logic [data_width-1:0] rd_data_a,
	input logic [data_width-1:0] rd_data_b,
	input int test_id,
	output int checks,
	output int errors
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int depth = 1 << addr_width;

	logic [data_width-1:0] model [depth];
	logic [addr_width-1:0] req_addr; // own copy of the accepted request
	logic [data_width-1:0] req_data;
	logic busy = 1'b0;     // accepted, ack not seen yet
	logic acked = 1'b0;
	logic dropping = 1'b0; // wr_req seen low with ack high
	int wait_cycles = 0;
	int prev_id = 0;
	int test_checks = 0;
	int test_errors = 0;
	int total_checks = 0;
	int total_errors = 0;

	assign checks = total_checks;
	assign errors = total_errors;

	function automatic string test_name(input int id);
		case (id)
			1: return "reset_state";
			2: return "random_writes";
			3: return "same_address";
			4: return "handshake_timing";
			5: return "end_registers";
			default: return "setup";
		endcase
	endfunction

	task automatic compare(input string what, input logic [data_width-1:0] expected,
		input logic [data_width-1:0] actual);
		test_checks++;
		total_checks++;
		if (actual !== expected)
		begin
			test_errors++;
			total_errors++;
			$display("error test %s: %s expected %0h actual %0h", test_name(test_id), what,
				expected, actual);
		end
	endtask

	// sampled view of the four-phase protocol
	task automatic follow_handshake();
		if (dropping)
		begin
			compare("wr_ack one cycle after wr_req low", '0, data_width'(wr_ack));
			dropping = 1'b0;
			acked = 1'b0;
		end
		else if (busy)
		begin
			wait_cycles++;
			if (wait_cycles < 2)
			begin
				compare("wr_ack one cycle after accept", '0, data_width'(wr_ack));
			end
			else
			begin
				compare("wr_ack two cycles after accept", data_width'(1'b1), data_width'(wr_ack));
				model[req_addr] = req_data; // readable from the ack edge on
				busy = 1'b0;
				acked = 1'b1;
			end
		end
		else if (acked)
		begin
			compare("wr_ack while held", data_width'(1'b1), data_width'(wr_ack));
			dropping = !wr_req;
		end
		else
		begin
			compare("wr_ack while idle", '0, data_width'(wr_ack));
			if (wr_req)
			begin
				req_addr = wr_addr;
				req_data = wr_data;
				busy = 1'b1;
				wait_cycles = 0;
			end
		end
	endtask

	always @(posedge e)
	begin
		if (test_id != prev_id)
		begin
			if (prev_id != 0)
			begin
				$display("test %s finished: %0d checks, %0d errors", test_name(prev_id),
					test_checks, test_errors);
			end
			test_checks = 0;
			test_errors = 0;
			prev_id = test_id;
		end
		if (reset)
		begin
			for (int i = 0; i < depth; i++)
			begin
				model[i] = '0;
			end
			busy = 1'b0;
			acked = 1'b0;
			dropping = 1'b0;
		end
		else
		begin
			follow_handshake();
			compare($sformatf("port a at %0d", rd_addr_a), model[rd_addr_a], rd_data_a);
			compare($sformatf("port b at %0d", rd_addr_b), model[rd_addr_b], rd_data_b);
		end
	end

endmodule

// File: verif/register_file_tb.sv
module register_file_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int data_width = 32;
	localparam int addr_width = 5;
	localparam int depth = 1 << addr_width;
	localparam int half_period = 20;
	localparam int num_writes = 200;
	localparam int timeout_cycles = 50;

	logic e = 1'b0;
	logic reset;
	logic wr_req;
	logic [addr_width-1:0] wr_addr;
	logic [data_width-1:0] wr_data;
	logic wr_ack;
	logic [addr_width-1:0] rd_addr_a;
	logic [addr_width-1:0] rd_addr_b;
	logic [data_width-1:0] rd_data_a;
	logic [data_width-1:0] rd_data_b;

	int seed = 32'h7447883e;
	int test_id;
	int timeouts = 0;
	int checks;
	int errors;

	always #(half_period) e = ~e;

	register_file #(.data_width(data_width), .addr_width(addr_width)) UUT (
		.e(e), .reset(reset),
		.wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_ack(wr_ack),
		.rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a), .rd_data_b(rd_data_b)
	);

	register_file_monitor #(.data_width(data_width), .addr_width(addr_width)) u_monitor (
		.e(e), .reset(reset),
		.wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_ack(wr_ack),
		.rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
		.test_id(test_id), .checks(checks), .errors(errors)
	);

	bind write_port write_port_chk u_chk (
		.e(e), .reset(reset), .wr_req(wr_req), .wr_ack(wr_ack), .we(we), .state(state)
	);

	task automatic wait_for_ack(input logic level);
		int cycles;
		cycles = 0;
		@(posedge e);
		while (wr_ack !== level && cycles < timeout_cycles)
		begin
			@(posedge e);
			cycles++;
		end
		if (wr_ack !== level)
		begin
			timeouts++;
			$display("timeout: wr_ack did not go to %0d within %0d cycles", level, timeout_cycles);
		end
	endtask

	// one full four-phase write, then hold the request for extra cycles
	task automatic write_reg(input logic [addr_width-1:0] addr, input logic [data_width-1:0] data,
		input int hold);
		wr_req <= 1'b1;
		wr_addr <= addr;
		wr_data <= data;
		wait_for_ack(1'b1);
		rd_addr_a <= addr_width'($random(seed));
		rd_addr_b <= addr; // just written
		repeat (hold) @(posedge e);
		wr_req <= 1'b0;
		wr_addr <= addr_width'($random(seed)); // no longer looked at
		wr_data <= data_width'($random(seed));
		wait_for_ack(1'b0);
	endtask

	task automatic read_pair(input logic [addr_width-1:0] addr_a, input logic [addr_width-1:0] addr_b);
		rd_addr_a <= addr_a;
		rd_addr_b <= addr_b;
		@(posedge e);
	endtask

	initial
	begin
		logic [addr_width-1:0] addr;
		reset <= 1'b1;
		wr_req <= 1'b0;
		wr_addr <= '0;
		wr_data <= '0;
		rd_addr_a <= '0;
		rd_addr_b <= '0;
		test_id <= 0;
		repeat (4) @(posedge e);
		reset <= 1'b0;

		test_id <= 1;
		for (int i = 0; i < depth; i++)
		begin
			read_pair(addr_width'(i), addr_width'(depth - 1 - i));
		end

		test_id <= 2;
		repeat (num_writes) write_reg(addr_width'($random(seed)), data_width'($random(seed)), 0);

		test_id <= 3;
		repeat (depth)
		begin
			addr = addr_width'($random(seed));
			read_pair(addr, addr);
		end

		test_id <= 4;
		repeat (20)
		begin
			write_reg(addr_width'($random(seed)), data_width'($random(seed)),
				int'($unsigned($random(seed)) % 6));
		end

		test_id <= 5;
		write_reg('0, data_width'($random(seed)), 0);
		write_reg(addr_width'(depth - 1), data_width'($random(seed)), 0);
		read_pair('0, addr_width'(1));
		read_pair(addr_width'(depth - 1), addr_width'(depth - 2));
		read_pair('0, addr_width'(depth - 1));

		test_id <= 0;
		repeat (2) @(posedge e);
		@(negedge e); // counts are settled here
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0 && checks > 0)
		begin
			$display("SIMULATION PASSED");
		end
		else
		begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: project.f
logic/regfile_pkg.sv
logic/write_port.sv
logic/reg_bank.sv
logic/register_file.sv
verif/write_port_chk.sv
verif/register_file_monitor.sv
verif/register_file_tb.sv

// File: run.sh
#!/bin/sh
# build with Verilator and run the register file testbench from the project root
cd "$(dirname "$0")" \
	&& verilator --binary --assert --timescale 1ns/1ps --top-module register_file_tb \
		-Mdir obj_dir -f project.f \
	&& ./obj_dir/Vregister_file_tb | grep "SIMULATION PASSED" \
	&& echo "run ok" \
	|| { echo "run not ok"; exit 1; }
